// ==== verilog/afu_pkg.sv ====
`default_nettype none

package afu_pkg;

  // host memory addressing, in cachelines
  localparam int ADDR_W = 58;
  localparam int MDATA_W = 14;

  // context word written by software
  localparam int CONTEXT_W = 512;

  // byte address fields in the context
  // the cacheline address drops the low 6 bits
  localparam int FILTER_LSB = 256;
  localparam int DEST_LSB = 448;

  // output buffering
  localparam int FIFO_DEPTH_BITS = 4;
  localparam int FIFO_DEPTH = 1 << FIFO_DEPTH_BITS;

  // metadata bit 0 marks what a read carries
  localparam logic TAG_IMAGE = 1'b0;
  localparam logic TAG_KERNEL = 1'b1;

  // per-job values taken from the context at start
  // filter_addr doubles as the image line count
  typedef struct packed {
    logic [ADDR_W-1:0] filter_addr;
    logic [ADDR_W-1:0] dest_addr;
  } job_t;

endpackage

`default_nettype wire

// ==== verilog/cacheline_pkg.sv ====
`default_nettype none

package cacheline_pkg;

  localparam int LINE_W = 512;
  localparam int LANES = 8;

  // one complex sample, real part in the low half
  typedef struct packed {
    logic signed [31:0] im;
    logic signed [31:0] re;
  } complex_t;

  // lane k sits at bits 64k and up
  typedef union packed {
    logic [LINE_W-1:0] raw;
    complex_t [LANES-1:0] lane;
  } cacheline_u;

  typedef struct packed {
    logic [afu_pkg::ADDR_W-1:0] addr;
    logic [afu_pkg::MDATA_W-1:0] mdata;
  } rd_req_t;

  typedef struct packed {
    logic [afu_pkg::ADDR_W-1:0] addr;
    logic [afu_pkg::MDATA_W-1:0] mdata;
    logic [LINE_W-1:0] data;
  } wr_req_t;

endpackage

`default_nettype wire

// ==== verilog/read_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_scheduler (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic [afu_pkg::CONTEXT_W-1:0] afu_context,
  input  logic rd_req_almostfull,
  input  logic pop,
  output cacheline_pkg::rd_req_t rd_req,
  output logic rd_req_en,
  output afu_pkg::job_t job
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_KERNEL,
    S_IMAGE,
    S_FINISHED
  } state_t;

  state_t state;
  logic start_q;
  logic start_rise;
  logic kernel_issue;
  logic image_issue;
  logic [afu_pkg::ADDR_W-1:0] image_addr;
  logic [afu_pkg::FIFO_DEPTH_BITS:0] outstanding;

  assign start_rise = start && !start_q;
  assign kernel_issue = state == S_KERNEL && !rd_req_almostfull;

  // image reads also need a free slot in the output FIFO
  assign image_issue = state == S_IMAGE && !rd_req_almostfull &&
                       image_addr != job.filter_addr &&
                       outstanding < afu_pkg::FIFO_DEPTH;

  always_ff @(posedge clk) begin
    if (reset) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      rd_req_en <= 1'b0;
    end else begin
      rd_req_en <= 1'b0;
      if (!start) begin
        state <= S_IDLE;
      end else begin
        case (state)
          S_IDLE: begin
            if (start_rise) begin
              state <= S_KERNEL;
            end
          end
          S_KERNEL: begin
            if (kernel_issue) begin
              rd_req_en <= 1'b1;
              state <= S_IMAGE;
            end
          end
          S_IMAGE: begin
            if (image_addr == job.filter_addr) begin
              state <= S_FINISHED;
            end else if (image_issue) begin
              rd_req_en <= 1'b1;
            end
          end
          default: begin
            // all reads sent, wait for start to drop
          end
        endcase
      end
    end
  end

  // job fields and request payload
  always_ff @(posedge clk) begin
    if (state == S_IDLE && start_rise) begin
      job.filter_addr <= afu_context[afu_pkg::FILTER_LSB+63:afu_pkg::FILTER_LSB+6];
      job.dest_addr <= afu_context[afu_pkg::DEST_LSB+63:afu_pkg::DEST_LSB+6];
      image_addr <= '0;
    end
    if (kernel_issue) begin
      rd_req.addr <= job.filter_addr;
      rd_req.mdata <= '0;
      rd_req.mdata[0] <= afu_pkg::TAG_KERNEL;
    end else if (image_issue) begin
      rd_req.addr <= image_addr;
      rd_req.mdata <= '0;
      rd_req.mdata[0] <= afu_pkg::TAG_IMAGE;
      image_addr <= image_addr + 1'b1;
    end
  end

  // credits: image lines in flight, returned on each write
  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= '0;
    end else begin
      case ({image_issue, pop})
        2'b10: outstanding <= outstanding + 1'b1;
        2'b01: outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  a_credit_limit: assert property (
    @(posedge clk) disable iff (reset) outstanding <= afu_pkg::FIFO_DEPTH
  ) else $error("read_scheduler: outstanding image lines above FIFO depth");

endmodule

`default_nettype wire

// ==== verilog/response_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module response_router (
  input  logic clk,
  input  logic reset,
  input  logic rd_rsp_valid,
  input  logic [afu_pkg::MDATA_W-1:0] rd_rsp_mdata,
  input  logic [cacheline_pkg::LINE_W-1:0] rd_rsp_data,
  output cacheline_pkg::cacheline_u kernel_line,
  output cacheline_pkg::cacheline_u image_line,
  output logic image_valid
);

  logic is_kernel;
  logic kernel_loaded;

  // only bit 0 of the metadata carries meaning
  assign is_kernel = rd_rsp_mdata[0] == afu_pkg::TAG_KERNEL;

  always_ff @(posedge clk) begin
    if (reset) begin
      image_valid <= 1'b0;
      kernel_loaded <= 1'b0;
    end else begin
      image_valid <= rd_rsp_valid && !is_kernel;
      if (rd_rsp_valid && is_kernel) begin
        kernel_loaded <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_rsp_valid && is_kernel) begin
      kernel_line.raw <= rd_rsp_data;
    end
    if (rd_rsp_valid && !is_kernel) begin
      image_line.raw <= rd_rsp_data;
    end
  end

  // kernel is requested first and memory answers in order
  a_kernel_first: assert property (
    @(posedge clk) disable iff (reset) (rd_rsp_valid && !is_kernel) |-> kernel_loaded
  ) else $error("response_router: image line arrived before any kernel line");

endmodule

`default_nettype wire

// ==== verilog/complex_mult_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module complex_mult_stage (
  input  logic clk,
  input  logic reset,
  input  cacheline_pkg::cacheline_u image_line,
  input  logic image_valid,
  input  cacheline_pkg::cacheline_u kernel_line,
  output cacheline_pkg::cacheline_u product_line,
  output logic product_valid
);

  cacheline_pkg::cacheline_u product_next;

  // (a + jb)(c + jd), results wrap to 32 bits
  function automatic cacheline_pkg::complex_t lane_mult(
    input cacheline_pkg::complex_t img,
    input cacheline_pkg::complex_t ker
  );
    logic signed [63:0] p_rr;
    logic signed [63:0] p_ii;
    logic signed [63:0] p_ri;
    logic signed [63:0] p_ir;
    cacheline_pkg::complex_t p;
    p_rr = img.re * ker.re;
    p_ii = img.im * ker.im;
    p_ri = img.re * ker.im;
    p_ir = img.im * ker.re;
    p.re = p_rr[31:0] - p_ii[31:0];
    p.im = p_ri[31:0] + p_ir[31:0];
    return p;
  endfunction

  // eight independent lanes
  always_comb begin
    for (int k = 0; k < cacheline_pkg::LANES; k++) begin
      product_next.lane[k] = lane_mult(image_line.lane[k], kernel_line.lane[k]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      product_valid <= 1'b0;
    end else begin
      product_valid <= image_valid;
    end
  end

  // a new line can enter every cycle
  always_ff @(posedge clk) begin
    if (image_valid) begin
      product_line <= product_next;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/write_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_generator (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  afu_pkg::job_t job,
  input  cacheline_pkg::cacheline_u product_line,
  input  logic product_valid,
  input  logic wr_req_almostfull,
  output cacheline_pkg::wr_req_t wr_req,
  output logic wr_req_en,
  output logic done
);

  logic [cacheline_pkg::LINE_W-1:0] fifo_mem [afu_pkg::FIFO_DEPTH];
  logic [afu_pkg::FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [afu_pkg::FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic [afu_pkg::FIFO_DEPTH_BITS:0] count;
  logic push;
  logic pop;
  logic full;
  logic empty;
  logic start_q;
  logic [afu_pkg::ADDR_W-1:0] write_count;

  assign push = product_valid;
  assign full = count == afu_pkg::FIFO_DEPTH;
  assign empty = count == '0;
  assign pop = !empty && !wr_req_almostfull;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= product_line.raw;
    end
  end

  // writes go to consecutive lines from dest_addr
  always_ff @(posedge clk) begin
    if (reset || !start) begin
      write_count <= '0;
    end else if (pop) begin
      write_count <= write_count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    wr_req.addr <= job.dest_addr + write_count;
    wr_req.mdata <= '0;
    wr_req.data <= fifo_mem[rd_ptr];
  end

  // start_q keeps done low until the new job is captured
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_req_en <= 1'b0;
      start_q <= 1'b0;
      done <= 1'b0;
    end else begin
      wr_req_en <= pop;
      start_q <= start;
      done <= start && start_q && write_count == job.filter_addr;
    end
  end

  // the read credit count must keep the FIFO from filling up
  a_no_overflow: assert property (
    @(posedge clk) disable iff (reset) push |-> !full
  ) else $error("write_generator: push into a full output FIFO");

endmodule

`default_nettype wire

// ==== verilog/conv_afu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_afu_top (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic [afu_pkg::CONTEXT_W-1:0] afu_context,
  input  logic rd_req_almostfull,
  input  logic rd_rsp_valid,
  input  logic [afu_pkg::MDATA_W-1:0] rd_rsp_mdata,
  input  logic [cacheline_pkg::LINE_W-1:0] rd_rsp_data,
  input  logic wr_req_almostfull,
  output cacheline_pkg::rd_req_t rd_req,
  output logic rd_req_en,
  output cacheline_pkg::wr_req_t wr_req,
  output logic wr_req_en,
  output logic done
);

  afu_pkg::job_t job;
  cacheline_pkg::cacheline_u kernel_line;
  cacheline_pkg::cacheline_u image_line;
  cacheline_pkg::cacheline_u product_line;
  logic image_valid;
  logic product_valid;

  read_scheduler u_read_scheduler (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .afu_context      (afu_context),
    .rd_req_almostfull(rd_req_almostfull),
    .pop              (wr_req_en),
    .rd_req           (rd_req),
    .rd_req_en        (rd_req_en),
    .job              (job)
  );

  response_router u_response_router (
    .clk         (clk),
    .reset       (reset),
    .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp_mdata(rd_rsp_mdata),
    .rd_rsp_data (rd_rsp_data),
    .kernel_line (kernel_line),
    .image_line  (image_line),
    .image_valid (image_valid)
  );

  complex_mult_stage u_complex_mult_stage (
    .clk          (clk),
    .reset        (reset),
    .image_line   (image_line),
    .image_valid  (image_valid),
    .kernel_line  (kernel_line),
    .product_line (product_line),
    .product_valid(product_valid)
  );

  write_generator u_write_generator (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .job              (job),
    .product_line     (product_line),
    .product_valid    (product_valid),
    .wr_req_almostfull(wr_req_almostfull),
    .wr_req           (wr_req),
    .wr_req_en        (wr_req_en),
    .done             (done)
  );

endmodule

`default_nettype wire

// ==== dv/conv_afu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_afu_tb;

  localparam int NUM_JOBS = 4;

  logic clk;
  logic reset;
  logic start;
  logic [afu_pkg::CONTEXT_W-1:0] afu_context;
  logic rd_req_almostfull;
  logic rd_rsp_valid;
  logic [afu_pkg::MDATA_W-1:0] rd_rsp_mdata;
  logic [cacheline_pkg::LINE_W-1:0] rd_rsp_data;
  logic wr_req_almostfull;
  cacheline_pkg::rd_req_t rd_req;
  logic rd_req_en;
  cacheline_pkg::wr_req_t wr_req;
  logic wr_req_en;
  logic done;

  integer seed = 32'h1aa4_6528;
  int errors = 0;
  int total_writes = 0;
  int watchdog_cycles = 0;
  int cycle_limit = 0;

  // current job as seen by the host memory
  logic [afu_pkg::ADDR_W-1:0] job_filter [NUM_JOBS];
  logic [afu_pkg::ADDR_W-1:0] cur_filter;
  logic [afu_pkg::ADDR_W-1:0] cur_dest;
  cacheline_pkg::cacheline_u cur_kernel;
  logic [cacheline_pkg::LINE_W-1:0] img_mem [64];

  // responses leave the memory model in request order
  int rd_idx;
  int wr_idx;
  int cycle_now = 0;
  int last_due = 0;
  logic [afu_pkg::ADDR_W-1:0] rsp_addr [$];
  logic rsp_tag [$];
  int rsp_due [$];

  // write back-pressure runs
  logic wr_stall_level = 1'b0;
  int wr_stall_left = 0;

  conv_afu_top dut (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .afu_context      (afu_context),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_rsp_valid     (rd_rsp_valid),
    .rd_rsp_mdata     (rd_rsp_mdata),
    .rd_rsp_data      (rd_rsp_data),
    .wr_req_almostfull(wr_req_almostfull),
    .rd_req           (rd_req),
    .rd_req_en        (rd_req_en),
    .wr_req           (wr_req),
    .wr_req_en        (wr_req_en),
    .done             (done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    watchdog_cycles = watchdog_cycles + 1;
    if (cycle_limit > 0 && watchdog_cycles >= cycle_limit) begin
      $display("Run timed out after %0d cycles before all jobs finished", watchdog_cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [511:0] got,
                             input logic [511:0] expected);
    if (got !== expected) begin
      errors++;
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic random_line(output logic [cacheline_pkg::LINE_W-1:0] line);
    for (int i = 0; i < cacheline_pkg::LINE_W / 32; i++) begin
      line[32*i +: 32] = $random(seed);
    end
  endtask

  // both parts of each lane product keep the low 32 bits
  function automatic cacheline_pkg::cacheline_u model_product(
    input cacheline_pkg::cacheline_u img,
    input cacheline_pkg::cacheline_u ker
  );
    cacheline_pkg::cacheline_u p;
    for (int k = 0; k < cacheline_pkg::LANES; k++) begin
      p.lane[k].re = img.lane[k].re * ker.lane[k].re - img.lane[k].im * ker.lane[k].im;
      p.lane[k].im = img.lane[k].re * ker.lane[k].im + img.lane[k].im * ker.lane[k].re;
    end
    return p;
  endfunction

  // check outputs, answer reads and drive new inputs for one clock
  task automatic service_cycle();
    int due;
    cacheline_pkg::cacheline_u expect_line;
    @(negedge clk);
    cycle_now++;
    if (rd_req_en) begin
      check_value("rd_req_almostfull at read issue", rd_req_almostfull, 0);
      if (rd_idx == 0) begin
        check_value("kernel read address", rd_req.addr, cur_filter);
        check_value("kernel read mdata", rd_req.mdata, afu_pkg::TAG_KERNEL);
      end else begin
        check_value("image read address", rd_req.addr, rd_idx - 1);
        check_value("image read mdata", rd_req.mdata, afu_pkg::TAG_IMAGE);
        // no more image lines in flight than the output FIFO holds
        if (rd_idx - 1 - wr_idx >= (1 << afu_pkg::FIFO_DEPTH_BITS)) begin
          errors++;
          $display("Error at %0t ns: image read issued with %0d lines outstanding",
                   $time, rd_idx - 1 - wr_idx);
        end
      end
      if (rd_idx > cur_filter) begin
        errors++;
        $display("Error at %0t ns: read request beyond the last image line", $time);
      end
      rd_idx++;
      due = cycle_now + 1 + ({$random(seed)} % 6);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      rsp_addr.push_back(rd_req.addr);
      rsp_tag.push_back(rd_req.mdata[0]);
      rsp_due.push_back(due);
    end
    if (wr_req_en) begin
      check_value("wr_req_almostfull at write issue", wr_req_almostfull, 0);
      if (wr_idx >= cur_filter) begin
        errors++;
        $display("Error at %0t ns: more writes than image lines in the job", $time);
      end else begin
        expect_line = model_product(img_mem[wr_idx], cur_kernel);
        check_value("write address", wr_req.addr, cur_dest + wr_idx);
        check_value("write mdata", wr_req.mdata, 0);
        check_value("write data", wr_req.data, expect_line.raw);
      end
      wr_idx++;
    end
    if (done) begin
      check_value("writes seen at done", wr_idx, cur_filter);
    end
    rd_rsp_valid = 1'b0;
    rd_rsp_mdata = '0;
    if (rsp_due.size() > 0 && rsp_due[0] <= cycle_now) begin
      rd_rsp_valid = 1'b1;
      rd_rsp_mdata[0] = rsp_tag[0];
      rd_rsp_data = rsp_tag[0] ? cur_kernel.raw : img_mem[rsp_addr[0][5:0]];
      void'(rsp_addr.pop_front());
      void'(rsp_tag.pop_front());
      void'(rsp_due.pop_front());
    end
    // back-pressure about a quarter of the time
    rd_req_almostfull = ({$random(seed)} % 4) == 0;
    // write stalls come in runs long enough to fill the output FIFO
    if (wr_stall_left == 0) begin
      wr_stall_level = ({$random(seed)} % 4) == 0;
      wr_stall_left = 1 + ({$random(seed)} % 24);
    end
    wr_req_almostfull = wr_stall_level;
    wr_stall_left--;
  endtask

  task automatic run_job(input int j);
    int err_base;
    logic [afu_pkg::CONTEXT_W-1:0] ctx_word;
    logic [cacheline_pkg::LINE_W-1:0] line;
    err_base = errors;
    cur_filter = job_filter[j];
    cur_dest = {$random(seed), $random(seed)};
    random_line(line);
    cur_kernel.raw = line;
    for (int i = 0; i < cur_filter; i++) begin
      random_line(line);
      img_mem[i] = line;
    end
    rd_idx = 0;
    wr_idx = 0;
    // unused context bits stay random
    for (int i = 0; i < afu_pkg::CONTEXT_W / 32; i++) begin
      ctx_word[32*i +: 32] = $random(seed);
    end
    ctx_word[afu_pkg::FILTER_LSB+6 +: afu_pkg::ADDR_W] = cur_filter;
    ctx_word[afu_pkg::DEST_LSB+6 +: afu_pkg::ADDR_W] = cur_dest;
    afu_context = ctx_word;
    start = 1'b1;
    while (!done) begin
      service_cycle();
    end
    start = 1'b0;
    repeat (2) service_cycle();
    check_value("done after start dropped", done, 0);
    check_value("read count", rd_idx, cur_filter + 1);
    check_value("write count", wr_idx, cur_filter);
    check_value("pending read responses", rsp_due.size(), 0);
    total_writes += wr_idx;
    $display("job %0d: %0d lines to dest %0h, %0s", j, cur_filter, cur_dest,
             errors == err_base ? "ok" : "mismatches");
  endtask

  initial begin
    int limit;
    reset = 1'b1;
    start = 1'b0;
    afu_context = '0;
    rd_req_almostfull = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_mdata = '0;
    rd_rsp_data = '0;
    wr_req_almostfull = 1'b0;
    cur_filter = '0;
    cur_dest = '0;
    cur_kernel.raw = '0;
    rd_idx = 0;
    wr_idx = 0;
    limit = 1000;
    for (int j = 0; j < NUM_JOBS; j++) begin
      job_filter[j] = 1 + ({$random(seed)} % 40);
      limit += 200 * job_filter[j];
    end
    cycle_limit = limit;
    repeat (16) service_cycle();
    reset = 1'b0;
    check_value("rd_req_en after reset", rd_req_en, 0);
    check_value("wr_req_en after reset", wr_req_en, 0);
    check_value("done after reset", done, 0);
    repeat (4) service_cycle();
    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(j);
    end
    $display("%0d jobs, %0d writes checked, %0d errors", NUM_JOBS, total_writes, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/afu_pkg.sv
verilog/cacheline_pkg.sv
verilog/read_scheduler.sv
verilog/response_router.sv
verilog/complex_mult_stage.sv
verilog/write_generator.sv
verilog/conv_afu_top.sv
dv/conv_afu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module conv_afu_tb \
  -o conv_afu_tb > build.log 2>&1 \
  && ./obj_dir/conv_afu_tb > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && { echo "simulation FAILED"; exit 1; } \
  || { echo "simulation finished without failures"; exit 0; }
